// File: Bender.yml
package:
  name: soc_audio

sources:
  - source/soc_pkg.sv
  - source/cpu_ram.sv
  - source/adau_spi_config.sv
  - source/adau_i2s_tx.sv
  - source/adau_interface.sv
  - source/cpu_bus_logic.sv
  - source/soc_top.sv
  - target: simulation
    files:
      - sim/soc_checker.sv
      - sim/tb_soc_top.sv

// File: sim.f
source/soc_pkg.sv
source/cpu_ram.sv
source/adau_spi_config.sv
source/adau_i2s_tx.sv
source/adau_interface.sv
source/cpu_bus_logic.sv
source/soc_top.sv
sim/soc_checker.sv
sim/tb_soc_top.sv

// File: sim/soc_checker.sv
`timescale 1ns/1ps

module soc_checker
    import soc_pkg::*;
(
    input logic          clk,
    input logic          reset,
    input logic          ready,
    input mem_req_t      req,
    input logic [31:0]   rdata,
    input logic          cclk,
    input logic          clatch_n,
    input logic          cdata,
    input logic          bclk,
    input logic          lrclk,
    input logic          sdata
);

    int errors        = 0;
    int cfg_frames    = 0;
    int sample_frames = 0;
    int zero_frames   = 0;

    logic [31:0]   exp_data [$];
    logic [31:0]   exp_mask [$];
    audio_sample_t exp_samples [$];

    logic [CFG_WORD_W-1:0] cfg_word;
    int                    cfg_bits = 0;
    logic [63:0]           frame_bits;
    int                    pos      = 0;
    logic                  active   = 1'b0;
    logic                  prev_lr  = 1'b0;

    task automatic flag_mismatch(input string name, input logic [47:0] exp,
                                 input logic [47:0] act);
        $display("FAILED at time %0t: %s expected %h, got %h", $time, name, exp, act);
        errors++;
    endtask

    task automatic expect_read(input logic [31:0] data, input logic [31:0] mask);
        exp_data.push_back(data);
        exp_mask.push_back(mask);
    endtask

    task automatic expect_sample(input audio_sample_t s);
        exp_samples.push_back(s);
    endtask

    // Read data is stable in the second half of the ready cycle
    always @(negedge clk) begin : read_monitor
        logic [31:0] exp;
        logic [31:0] mask;
        if (!reset && ready === 1'b1 && req.wstrb == 4'b0) begin
            if (exp_data.size() == 0) begin
                $display("Read completed at time %0t with no expected data", $time);
                errors++;
            end else begin
                exp  = exp_data.pop_front();
                mask = exp_mask.pop_front();
                if ((rdata & mask) !== (exp & mask)) begin
                    flag_mismatch("rdata", {16'b0, exp}, {16'b0, rdata});
                end
            end
        end
    end

    always @(posedge cclk) begin
        if (!reset && clatch_n === 1'b0) begin
            cfg_word = {cfg_word[CFG_WORD_W-2:0], cdata};
            cfg_bits++;
        end
    end

    // Rising latch closes a control frame
    always @(posedge clatch_n) begin
        if (!reset && cfg_bits != 0) begin
            if (cfg_bits != CFG_WORD_W) begin
                $display("Codec frame %0d carried %0d bits instead of %0d",
                         cfg_frames, cfg_bits, CFG_WORD_W);
                errors++;
            end else if (cfg_frames >= INIT_WORDS) begin
                $display("Extra codec frame %h after the init table", cfg_word);
                errors++;
            end else if (cfg_word !== ADAU_INIT_TABLE[cfg_frames]) begin
                flag_mismatch("cdata frame", {16'b0, ADAU_INIT_TABLE[cfg_frames]},
                              {16'b0, cfg_word});
            end
            cfg_frames++;
            cfg_bits = 0;
        end
    end

    task automatic check_frame();
        audio_sample_t got;
        audio_sample_t exp;
        got = '{left: frame_bits[62:39], right: frame_bits[30:7]};
        // Slot bit 0 and the bits after the 24 sample bits must be zero
        if ((frame_bits & ~64'h7FFF_FF80_7FFF_FF80) != 64'b0) begin
            $display("Padding bits on sdata not zero at time %0t", $time);
            errors++;
        end
        if (got == '0) begin
            zero_frames++;
        end else if (exp_samples.size() == 0) begin
            $display("Sample %h decoded at time %0t with none expected", got, $time);
            errors++;
            sample_frames++;
        end else begin
            exp = exp_samples.pop_front();
            if (got !== exp) begin
                flag_mismatch("sdata sample", exp, got);
            end
            sample_frames++;
        end
    endtask

    always @(posedge bclk) begin
        if (!reset) begin
            if (prev_lr && !lrclk) begin
                active = 1'b1;
                pos    = 0;
            end else begin
                pos++;
            end
            prev_lr = lrclk;
            if (active && pos < 2 * SLOT_BITS) begin
                if (lrclk !== (pos >= SLOT_BITS)) begin
                    $display("lrclk wrong at bit %0d of a frame, time %0t", pos, $time);
                    errors++;
                end
                frame_bits[2*SLOT_BITS-1-pos] = sdata;
                if (pos == 2 * SLOT_BITS - 1) begin
                    check_frame();
                end
            end
        end
    end

    task automatic final_checks();
        if (cfg_frames != INIT_WORDS) begin
            $display("Expected %0d codec frames but decoded %0d", INIT_WORDS, cfg_frames);
            errors++;
        end
        if (exp_samples.size() != 0) begin
            $display("%0d expected samples never appeared on sdata", exp_samples.size());
            errors++;
        end
        if (exp_data.size() != 0) begin
            $display("%0d expected reads never completed", exp_data.size());
            errors++;
        end
    endtask

endmodule

// File: sim/tb_soc_top.sv
`timescale 1ns/1ps

module tb_soc_top
    import soc_pkg::*;
();

    localparam int CFG_CYCLES     = INIT_WORDS * (CFG_WORD_W + CFG_GAP) * CCLK_DIV;
    localparam int FRAME_CYCLES   = 2 * SLOT_BITS * BCLK_DIV;
    localparam int BUS_CYCLES     = 1500;
    // Configuration, sixteen frames of audio and the bus traffic, three times over
    localparam int TIMEOUT_CYCLES = 3 * (CFG_CYCLES + 16 * FRAME_CYCLES + BUS_CYCLES);
    localparam int BUS_WAIT       = 2 * FRAME_CYCLES;
    localparam int WAIT_LIMIT     = 8 * FRAME_CYCLES;
    localparam int CFG_COUNT      = 0;
    localparam int SAMPLE_COUNT   = 1;
    localparam int ZERO_COUNT     = 2;

    logic        clk;
    logic        reset;
    logic        valid;
    mem_req_t    req;
    logic [31:0] rdata;
    logic        ready;
    logic [7:0]  dip;
    logic [4:0]  buttons;
    logic [7:0]  led;
    logic        cclk;
    logic        clatch_n;
    logic        cdata;
    logic        sdata;
    logic        bclk;
    logic        lrclk;

    int          tb_errors   = 0;
    int          cycle_count = 0;
    logic [31:0] ram_model [int];
    logic [7:0]  led_model;

    soc_top dut0 (
        .clk(clk), .reset(reset), .valid(valid), .req(req), .rdata(rdata), .ready(ready),
        .dip(dip), .buttons(buttons), .led(led), .cclk(cclk), .clatch_n(clatch_n),
        .cdata(cdata), .sdata(sdata), .bclk(bclk), .lrclk(lrclk)
    );

    soc_checker chk0 (
        .clk(clk), .reset(reset), .ready(ready), .req(req), .rdata(rdata), .cclk(cclk),
        .clatch_n(clatch_n), .cdata(cdata), .bclk(bclk), .lrclk(lrclk), .sdata(sdata)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial begin
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Run stopped after %0d cycles without finishing", TIMEOUT_CYCLES);
        $display("Regression failed");
        $finish;
    end

    function automatic logic [31:0] merge_bytes(input logic [31:0] old,
                                                input logic [31:0] wdata,
                                                input logic [3:0]  wstrb);
        logic [31:0] merged;
        merged = old;
        for (int i = 0; i < 4; i++) begin
            if (wstrb[i]) begin
                merged[8*i +: 8] = wdata[8*i +: 8];
            end
        end
        return merged;
    endfunction

    // Expected IO read value from the register map
    function automatic logic [31:0] io_model(input logic [31:0] offset, input logic full,
                                             input logic done);
        case (offset)
            REG_LED:          return {24'b0, led_model};
            REG_INPUTS:       return {19'b0, buttons, dip};
            REG_AUDIO_STATUS: return {30'b0, done, full};
            default:          return 32'b0;
        endcase
    endfunction

    function automatic int checker_count(input int sel);
        case (sel)
            CFG_COUNT:    return chk0.cfg_frames;
            SAMPLE_COUNT: return chk0.sample_frames;
            default:      return chk0.zero_frames;
        endcase
    endfunction

    task automatic compare_value(input string name, input logic [31:0] exp,
                                 input logic [31:0] act);
        if (exp !== act) begin
            $display("FAILED at time %0t: %s expected %h, got %h", $time, name, exp, act);
            tb_errors++;
        end
    endtask

    task automatic bus_access(input logic [31:0] addr, input logic [31:0] wdata,
                              input logic [3:0] wstrb, input bit check_lat,
                              output logic [31:0] data);
        int cycles;
        @(negedge clk);
        valid  = 1'b1;
        req    = '{addr: addr, wdata: wdata, wstrb: wstrb};
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while (ready !== 1'b1 && cycles < BUS_WAIT);
        if (ready !== 1'b1) begin
            $display("No ready for address %h within %0d cycles", addr, cycles);
            tb_errors++;
        end else if (check_lat) begin
            compare_value("ready latency", 32'd1, cycles);
        end
        data = rdata;
        // Handshake completes on the next rising edge
        @(negedge clk);
        valid = 1'b0;
    endtask

    task automatic bus_write(input logic [31:0] addr, input logic [31:0] wdata,
                             input logic [3:0] wstrb, input bit check_lat);
        logic [31:0] unused;
        bus_access(addr, wdata, wstrb, check_lat, unused);
    endtask

    task automatic bus_read(input logic [31:0] addr, output logic [31:0] data);
        bus_access(addr, 32'b0, 4'b0, 1'b1, data);
    endtask

    task automatic read_check(input logic [31:0] addr, input logic [31:0] exp,
                              input logic [31:0] mask, output logic [31:0] data);
        chk0.expect_read(exp, mask);
        bus_read(addr, data);
    endtask

    task automatic wait_for(input int sel, input int target, input string what);
        int waited;
        waited = 0;
        while (checker_count(sel) < target && waited < WAIT_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (checker_count(sel) < target) begin
            $display("Gave up waiting for %s after %0d cycles", what, waited);
            tb_errors++;
        end
    endtask

    task automatic send_pair();
        audio_sample_t pair;
        logic [31:0]   rnd_l;
        logic [31:0]   rnd_r;
        rnd_l = $urandom;
        rnd_r = $urandom;
        // Left LSB set so a sample frame never looks like silence
        pair.left  = rnd_l[23:0] | 24'h1;
        pair.right = rnd_r[23:0];
        chk0.expect_sample(pair);
        bus_write(IO_BASE + REG_AUDIO_LEFT, {rnd_l[31:24], pair.left}, 4'hF, 1'b1);
        bus_write(IO_BASE + REG_AUDIO_RIGHT, {rnd_r[31:24], pair.right}, 4'hF, 1'b0);
    endtask

    initial begin
        logic [31:0] rnd;
        logic [31:0] data;
        logic [3:0]  strb;
        int          idx [40];
        int          zeros;
        bit          saw_full;
        void'($urandom(21189));
        reset    = 1'b1;
        valid    = 1'b0;
        req      = '0;
        dip      = 8'b0;
        buttons  = 5'b0;
        repeat (3) @(negedge clk);
        reset = 1'b0;

        // Full words first, then partial strobes over them
        for (int i = 0; i < 40; i++) begin
            idx[i] = $urandom_range(0, 2**RAM_ADDR_W - 1);
            rnd    = $urandom;
            bus_write(RAM_BASE + idx[i] * 4, rnd, 4'hF, 1'b1);
            ram_model[idx[i]] = rnd;
        end
        for (int i = 0; i < 40; i++) begin
            data = $urandom_range(1, 14);
            strb = data[3:0];
            rnd  = $urandom;
            bus_write(RAM_BASE + idx[i] * 4, rnd, strb, 1'b1);
            ram_model[idx[i]] = merge_bytes(ram_model[idx[i]], rnd, strb);
        end
        for (int i = 0; i < 40; i++) begin
            read_check(RAM_BASE + idx[i] * 4, ram_model[idx[i]], 32'hFFFF_FFFF, data);
        end

        rnd       = $urandom;
        led_model = rnd[7:0];
        bus_write(IO_BASE + REG_LED, rnd, 4'hF, 1'b1);
        compare_value("led", {24'b0, led_model}, {24'b0, led});
        read_check(IO_BASE + REG_LED, io_model(REG_LED, 1'b0, 1'b0), 32'hFFFF_FFFF, data);
        rnd     = $urandom;
        dip     = rnd[7:0];
        buttons = rnd[12:8];
        read_check(IO_BASE + REG_INPUTS, io_model(REG_INPUTS, 1'b0, 1'b0), 32'hFFFF_FFFF, data);
        bus_write(IO_BASE + 32'h40, $urandom, 4'hF, 1'b1);
        read_check(IO_BASE + 32'h40, 32'b0, 32'hFFFF_FFFF, data);
        read_check(32'h0010_0000, 32'b0, 32'hFFFF_FFFF, data);

        wait_for(CFG_COUNT, INIT_WORDS, "codec configuration frames");
        read_check(IO_BASE + REG_AUDIO_STATUS, io_model(REG_AUDIO_STATUS, 1'b0, 1'b1),
                   32'hFFFF_FFFF, data);

        for (int i = 0; i < 6; i++) begin
            send_pair();
        end
        wait_for(SAMPLE_COUNT, 6, "six decoded sample frames");
        zeros = chk0.zero_frames;
        wait_for(ZERO_COUNT, zeros + 1, "a zero frame after the queue drained");

        // Burst of eight pairs, full bit is free in the status reads
        saw_full = 1'b0;
        for (int i = 0; i < 8; i++) begin
            send_pair();
            read_check(IO_BASE + REG_AUDIO_STATUS, io_model(REG_AUDIO_STATUS, 1'b0, 1'b1),
                       32'hFFFF_FFFE, data);
            if (data[0]) begin
                saw_full = 1'b1;
            end
        end
        if (!saw_full) begin
            $display("Audio queue never reported full during the burst");
            tb_errors++;
        end
        wait_for(SAMPLE_COUNT, 14, "fourteen decoded sample frames");
        zeros = chk0.zero_frames;
        wait_for(ZERO_COUNT, zeros + 1, "a zero frame after the burst drained");

        chk0.final_checks();
        $display("Checks done: %0d testbench errors, %0d checker errors",
                 tb_errors, chk0.errors);
        if (tb_errors + chk0.errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

// File: source/adau_i2s_tx.sv
`timescale 1ns/1ps

module adau_i2s_tx
    import soc_pkg::*;
(
    input  logic          clk,
    input  logic          reset,
    input  audio_sample_t sample,
    input  logic          sample_avail,
    output logic          sample_rd,
    output logic          sdata,
    output logic          bclk,
    output logic          lrclk
);

    logic [$clog2(BCLK_DIV)-1:0]    div_cnt;
    logic [$clog2(2*SLOT_BITS)-1:0] bit_cnt;
    logic [2*SLOT_BITS-1:0]         shift;
    logic [2*SLOT_BITS-1:0]         frame;
    logic                           period_start;

    assign period_start = (div_cnt == 0);
    assign sample_rd    = period_start && (bit_cnt == 0);

    // Each channel delayed by one bclk from its lrclk edge, zero padded
    assign frame = sample_avail ?
        {1'b0, sample.left, {(SLOT_BITS - SAMPLE_W - 1){1'b0}},
         1'b0, sample.right, {(SLOT_BITS - SAMPLE_W - 1){1'b0}}} : '0;

    always_ff @(posedge clk) begin
        if (reset) begin
            div_cnt <= '0;
            bit_cnt <= '0;
            bclk    <= 1'b0;
            lrclk   <= 1'b0;
            sdata   <= 1'b0;
        end else begin
            if (div_cnt == BCLK_DIV - 1) begin
                div_cnt <= '0;
                bit_cnt <= bit_cnt + 1'b1;
            end else begin
                div_cnt <= div_cnt + 1'b1;
            end

            // Falling bclk edge
            if (period_start) begin
                bclk  <= 1'b0;
                lrclk <= (bit_cnt >= SLOT_BITS);
                sdata <= sample_rd ? frame[2*SLOT_BITS-1] : shift[2*SLOT_BITS-1];
            end

            if (div_cnt == BCLK_DIV / 2) begin
                bclk <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (period_start) begin
            shift <= sample_rd ? frame << 1 : shift << 1;
        end
    end

endmodule

// File: source/adau_interface.sv
`timescale 1ns/1ps

module adau_interface
    import soc_pkg::*;
(
    input  logic          clk,
    input  logic          reset,
    input  audio_sample_t audio,
    input  logic          audio_valid,
    output logic          audio_full,
    output logic          init_done,
    output logic          cclk,
    output logic          clatch_n,
    output logic          cdata,
    output logic          sdata,
    output logic          bclk,
    output logic          lrclk
);

    audio_sample_t queue [AUDIO_QUEUE_DEPTH];

    logic [$clog2(AUDIO_QUEUE_DEPTH)-1:0]   wr_ptr;
    logic [$clog2(AUDIO_QUEUE_DEPTH)-1:0]   rd_ptr;
    logic [$clog2(AUDIO_QUEUE_DEPTH+1)-1:0] count;
    logic                                   push;
    logic                                   pop;
    logic                                   sample_rd;
    logic                                   sample_avail;
    audio_sample_t                          sample;

    assign audio_full   = (count == AUDIO_QUEUE_DEPTH);
    assign sample_avail = (count != 0);
    assign sample       = queue[rd_ptr];
    assign push         = audio_valid && !audio_full;
    assign pop          = sample_rd && sample_avail;

    always_ff @(posedge clk) begin
        if (push) begin
            queue[wr_ptr] <= audio;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    adau_spi_config cfg (
        .clk       (clk),
        .reset     (reset),
        .cclk      (cclk),
        .clatch_n  (clatch_n),
        .cdata     (cdata),
        .init_done (init_done)
    );

    adau_i2s_tx i2s (
        .clk          (clk),
        .reset        (reset),
        .sample       (sample),
        .sample_avail (sample_avail),
        .sample_rd    (sample_rd),
        .sdata        (sdata),
        .bclk         (bclk),
        .lrclk        (lrclk)
    );

endmodule

// File: source/adau_spi_config.sv
`timescale 1ns/1ps

module adau_spi_config
    import soc_pkg::*;
(
    input  logic clk,
    input  logic reset,
    output logic cclk,
    output logic clatch_n,
    output logic cdata,
    output logic init_done
);

    logic [$clog2(CCLK_DIV)-1:0]   div_cnt;
    logic [5:0]                    bit_cnt;
    logic [$clog2(INIT_WORDS)-1:0] word_idx;
    logic                          last_word;

    assign last_word = (word_idx == INIT_WORDS - 1);

    always_ff @(posedge clk) begin
        if (reset) begin
            div_cnt   <= '0;
            bit_cnt   <= '0;
            word_idx  <= '0;
            cclk      <= 1'b0;
            clatch_n  <= 1'b1;
            cdata     <= 1'b0;
            init_done <= 1'b0;
        end else if (!init_done) begin
            div_cnt <= div_cnt + 1'b1;

            // Start of a cclk period, data moves with the falling edge
            if (div_cnt == 0) begin
                cclk <= 1'b0;
                if (bit_cnt < CFG_WORD_W) begin
                    clatch_n <= 1'b0;
                    cdata    <= ADAU_INIT_TABLE[word_idx][CFG_WORD_W - 1 - bit_cnt];
                end else begin
                    clatch_n  <= 1'b1;
                    cdata     <= 1'b0;
                    // Table finished once the last frame closes
                    init_done <= last_word;
                end
            end

            if (div_cnt == CCLK_DIV / 2) begin
                cclk <= 1'b1;
            end

            if (div_cnt == CCLK_DIV - 1) begin
                div_cnt <= '0;
                if (bit_cnt == CFG_WORD_W + CFG_GAP - 1) begin
                    bit_cnt  <= '0;
                    word_idx <= word_idx + 1'b1;
                end else begin
                    bit_cnt <= bit_cnt + 1'b1;
                end
            end
        end
    end

endmodule

// File: source/cpu_bus_logic.sv
`timescale 1ns/1ps

module cpu_bus_logic
    import soc_pkg::*;
(
    input  logic          clk,
    input  logic          reset,
    input  logic          valid,
    input  mem_req_t      req,
    output logic [31:0]   rdata,
    output logic          ready,
    input  logic [7:0]    dip,
    input  logic [4:0]    buttons,
    output logic [7:0]    led,
    output logic          ram_valid,
    output ram_req_t      ram_req,
    input  logic [31:0]   ram_rdata,
    input  logic          ram_ready,
    output audio_sample_t audio,
    output logic          audio_valid,
    input  logic          audio_full,
    input  logic          init_done
);

    logic [31:0]         ram_off;
    logic [31:0]         io_off;
    logic [31:0]         io_rdata;
    logic [31:0]         rd_mux;
    logic                is_ram;
    logic                is_write;
    logic                right_wr;
    logic                io_fire;
    logic                io_ready;
    logic [SAMPLE_W-1:0] left_stage;

    assign ram_off  = req.addr - RAM_BASE;
    assign io_off   = req.addr - IO_BASE;
    assign is_ram   = (ram_off < (RAM_LIMIT - RAM_BASE));
    assign is_write = |req.wstrb;
    assign right_wr = is_write && (io_off == REG_AUDIO_RIGHT);

    // RAM requests go straight through
    assign ram_valid = valid && is_ram;
    assign ram_req   = '{addr: ram_off[RAM_ADDR_W+1:2], wdata: req.wdata, wstrb: req.wstrb};

    // io_ready blocks a second service of the held request
    // Right sample writes wait for room in the queue
    assign io_fire = valid && !is_ram && !io_ready && !(right_wr && audio_full);

    assign ready = is_ram ? ram_ready : io_ready;
    assign rdata = is_ram ? ram_rdata : io_rdata;

    always_comb begin
        case (io_off)
            REG_LED:          rd_mux = {24'b0, led};
            REG_INPUTS:       rd_mux = {19'b0, buttons, dip};
            REG_AUDIO_STATUS: rd_mux = {30'b0, init_done, audio_full};
            default:          rd_mux = 32'b0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            io_ready    <= 1'b0;
            audio_valid <= 1'b0;
            led         <= 8'b0;
        end else begin
            io_ready    <= io_fire;
            audio_valid <= io_fire && right_wr;
            if (io_fire && is_write && io_off == REG_LED) begin
                led <= req.wdata[7:0];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (io_fire) begin
            io_rdata <= rd_mux;
        end
        if (io_fire && is_write && io_off == REG_AUDIO_LEFT) begin
            left_stage <= req.wdata[SAMPLE_W-1:0];
        end
        // Pair goes out with the right sample
        if (io_fire && right_wr) begin
            audio <= '{left: left_stage, right: req.wdata[SAMPLE_W-1:0]};
        end
    end

endmodule

// File: source/cpu_ram.sv
`timescale 1ns/1ps

module cpu_ram
    import soc_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic        ram_valid,
    input  ram_req_t    ram_req,
    output logic [31:0] ram_rdata,
    output logic        ram_ready
);

    logic [31:0] mem [2**RAM_ADDR_W];
    logic        access;

    // Only the first cycle of a request touches the array
    assign access = ram_valid && !ram_ready;

    always_ff @(posedge clk) begin
        if (access) begin
            for (int i = 0; i < 4; i++) begin
                if (ram_req.wstrb[i]) begin
                    mem[ram_req.addr][8*i +: 8] <= ram_req.wdata[8*i +: 8];
                end
            end
            ram_rdata <= mem[ram_req.addr];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            ram_ready <= 1'b0;
        end else begin
            ram_ready <= access;
        end
    end

endmodule

// File: source/soc_pkg.sv
package soc_pkg;

    // Memory map
    localparam int          RAM_ADDR_W = 15;
    localparam logic [31:0] RAM_BASE   = 32'h0000_0000;
    localparam logic [31:0] RAM_LIMIT  = 32'h0002_0000;
    localparam logic [31:0] IO_BASE    = 32'h8000_0000;

    // IO register offsets from IO_BASE
    localparam logic [31:0] REG_LED          = 32'h0000_0000;
    localparam logic [31:0] REG_INPUTS       = 32'h0000_0004;
    localparam logic [31:0] REG_AUDIO_STATUS = 32'h0000_0008;
    localparam logic [31:0] REG_AUDIO_LEFT   = 32'h0000_000C;
    localparam logic [31:0] REG_AUDIO_RIGHT  = 32'h0000_0010;

    // Audio path
    localparam int SAMPLE_W          = 24;
    localparam int AUDIO_QUEUE_DEPTH = 4;
    localparam int BCLK_DIV          = 4;
    localparam int SLOT_BITS         = 32;

    // Codec control port
    localparam int CCLK_DIV   = 8;
    localparam int CFG_WORD_W = 32;
    localparam int CFG_GAP    = 2;
    localparam int INIT_WORDS = 4;

    // Chip address, register address, data
    localparam logic [CFG_WORD_W-1:0] ADAU_INIT_TABLE [INIT_WORDS] = '{
        32'h00_4000_01,
        32'h00_401C_21,
        32'h00_4029_03,
        32'h00_40F9_7F
    };

    typedef struct packed {
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [3:0]  wstrb;
    } mem_req_t;

    typedef struct packed {
        logic [RAM_ADDR_W-1:0] addr;
        logic [31:0]           wdata;
        logic [3:0]            wstrb;
    } ram_req_t;

    typedef struct packed {
        logic [SAMPLE_W-1:0] left;
        logic [SAMPLE_W-1:0] right;
    } audio_sample_t;

endpackage

// File: source/soc_top.sv
`timescale 1ns/1ps

module soc_top
    import soc_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic        valid,
    input  mem_req_t    req,
    output logic [31:0] rdata,
    output logic        ready,
    input  logic [7:0]  dip,
    input  logic [4:0]  buttons,
    output logic [7:0]  led,
    output logic        cclk,
    output logic        clatch_n,
    output logic        cdata,
    output logic        sdata,
    output logic        bclk,
    output logic        lrclk
);

    logic          ram_valid;
    ram_req_t      ram_req;
    logic [31:0]   ram_rdata;
    logic          ram_ready;
    audio_sample_t audio;
    logic          audio_valid;
    logic          audio_full;
    logic          init_done;

    cpu_bus_logic bus (
        .clk         (clk),
        .reset       (reset),
        .valid       (valid),
        .req         (req),
        .rdata       (rdata),
        .ready       (ready),
        .dip         (dip),
        .buttons     (buttons),
        .led         (led),
        .ram_valid   (ram_valid),
        .ram_req     (ram_req),
        .ram_rdata   (ram_rdata),
        .ram_ready   (ram_ready),
        .audio       (audio),
        .audio_valid (audio_valid),
        .audio_full  (audio_full),
        .init_done   (init_done)
    );

    cpu_ram ram (
        .clk       (clk),
        .reset     (reset),
        .ram_valid (ram_valid),
        .ram_req   (ram_req),
        .ram_rdata (ram_rdata),
        .ram_ready (ram_ready)
    );

    adau_interface adau (
        .clk         (clk),
        .reset       (reset),
        .audio       (audio),
        .audio_valid (audio_valid),
        .audio_full  (audio_full),
        .init_done   (init_done),
        .cclk        (cclk),
        .clatch_n    (clatch_n),
        .cdata       (cdata),
        .sdata       (sdata),
        .bclk        (bclk),
        .lrclk       (lrclk)
    );

endmodule
